// ==== common/axi_pkg.sv ====
package axi_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [LEN_W-1:0]   len_t;   // beats minus one.
    typedef logic [SIZE_W-1:0]  size_t;  // log2 of bytes per beat.
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [RESP_W-1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam burst_t BURST_FIXED = 2'b00;
    localparam burst_t BURST_INCR  = 2'b01;  // used for cache line fills.
    localparam burst_t BURST_WRAP  = 2'b10;

    // one 32-bit word per beat.
    localparam size_t SIZE_WORD = 3'd2;

endpackage

// ==== common/soc_map_pkg.sv ====
package soc_map_pkg;

    // core-local timer region of 64 KiB.
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] CLINT_MASK = 32'hFFFF_0000;

    localparam logic [31:0] MTIME_LO_OFF = 32'h0000_0000;
    localparam logic [31:0] MTIME_HI_OFF = 32'h0000_0004;

    typedef logic [63:0] mtime_t;

    typedef enum logic [1:0] {
        ARB_IDLE,   // waiting for a request.
        ARB_ADDR,   // owner's address routed to target.
        ARB_DATA    // target's read data routed to owner.
    } arb_state_t;

endpackage

// ==== bus/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter
    import axi_pkg::*;
    import soc_map_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,

    input  logic   fetch_arvalid,
    output logic   fetch_arready,
    input  addr_t  fetch_araddr,
    input  len_t   fetch_arlen,
    input  size_t  fetch_arsize,
    input  burst_t fetch_arburst,
    output logic   fetch_rvalid,
    input  logic   fetch_rready,
    output data_t  fetch_rdata,
    output resp_t  fetch_rresp,
    output logic   fetch_rlast,

    input  logic   lsu_arvalid,
    output logic   lsu_arready,
    input  addr_t  lsu_araddr,
    input  len_t   lsu_arlen,
    input  size_t  lsu_arsize,
    input  burst_t lsu_arburst,
    output logic   lsu_rvalid,
    input  logic   lsu_rready,
    output data_t  lsu_rdata,
    output resp_t  lsu_rresp,
    output logic   lsu_rlast,

    output logic   mem_arvalid,
    input  logic   mem_arready,
    output addr_t  mem_araddr,
    output len_t   mem_arlen,
    output size_t  mem_arsize,
    output burst_t mem_arburst,
    input  logic   mem_rvalid,
    output logic   mem_rready,
    input  data_t  mem_rdata,
    input  resp_t  mem_rresp,
    input  logic   mem_rlast,

    output logic   clint_arvalid,
    input  logic   clint_arready,
    output addr_t  clint_araddr,
    input  logic   clint_rvalid,
    output logic   clint_rready,
    input  data_t  clint_rdata,
    input  resp_t  clint_rresp,
    input  logic   clint_rlast
);

    arb_state_t state;
    arb_state_t state_nxt;
    logic       owner_lsu;   // 1 = load/store owns the bus.
    logic       tgt_clint;   // 1 = transaction goes to the clint.

    addr_t  req_addr;
    logic   req_clint;
    logic   sel_arvalid;
    logic   tgt_arready;
    logic   tgt_rvalid;
    data_t  tgt_rdata;
    resp_t  tgt_rresp;
    logic   tgt_rlast;
    logic   own_rready;
    logic   in_addr;
    logic   in_data;

    // lsu wins when both ask on the same edge.
    assign req_addr  = lsu_arvalid ? lsu_araddr : fetch_araddr;
    assign req_clint = (req_addr & CLINT_MASK) == CLINT_BASE;

    assign in_addr = state == ARB_ADDR;
    assign in_data = state == ARB_DATA;

    assign sel_arvalid = owner_lsu ? lsu_arvalid : fetch_arvalid;
    assign tgt_arready = tgt_clint ? clint_arready : mem_arready;

    assign mem_arvalid   = in_addr && !tgt_clint && sel_arvalid;
    assign clint_arvalid = in_addr && tgt_clint && sel_arvalid;
    assign mem_araddr    = owner_lsu ? lsu_araddr : fetch_araddr;
    assign mem_arlen     = owner_lsu ? lsu_arlen : fetch_arlen;
    assign mem_arsize    = owner_lsu ? lsu_arsize : fetch_arsize;
    assign mem_arburst   = owner_lsu ? lsu_arburst : fetch_arburst;
    assign clint_araddr  = mem_araddr;

    assign fetch_arready = in_addr && !owner_lsu && tgt_arready;
    assign lsu_arready   = in_addr && owner_lsu && tgt_arready;

    assign tgt_rvalid = tgt_clint ? clint_rvalid : mem_rvalid;
    assign tgt_rdata  = tgt_clint ? clint_rdata : mem_rdata;
    assign tgt_rresp  = tgt_clint ? clint_rresp : mem_rresp;
    assign tgt_rlast  = tgt_clint ? clint_rlast : mem_rlast;
    assign own_rready = owner_lsu ? lsu_rready : fetch_rready;

    assign mem_rready   = in_data && !tgt_clint && own_rready;
    assign clint_rready = in_data && tgt_clint && own_rready;

    assign fetch_rvalid = in_data && !owner_lsu && tgt_rvalid;
    assign fetch_rdata  = tgt_rdata;
    assign fetch_rresp  = tgt_rresp;
    assign fetch_rlast  = tgt_rlast;
    assign lsu_rvalid   = in_data && owner_lsu && tgt_rvalid;
    assign lsu_rdata    = tgt_rdata;
    assign lsu_rresp    = tgt_rresp;
    assign lsu_rlast    = tgt_rlast;

    always_comb begin
        state_nxt = state;
        unique case (state)
            ARB_IDLE: begin
                if (fetch_arvalid || lsu_arvalid) begin
                    state_nxt = ARB_ADDR;
                end
            end
            ARB_ADDR: begin
                if (sel_arvalid && tgt_arready) begin
                    state_nxt = ARB_DATA;
                end
            end
            ARB_DATA: begin
                if (tgt_rvalid && own_rready && tgt_rlast) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            owner_lsu <= 1'b0;
            tgt_clint <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ARB_IDLE && (fetch_arvalid || lsu_arvalid)) begin
                owner_lsu <= lsu_arvalid;
                tgt_clint <= req_clint;  // decoded once per grant.
            end
        end
    end

endmodule

// ==== clint/clint.sv ====
`timescale 1ns/1ps

module clint
    import axi_pkg::*;
    import soc_map_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,

    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,

    output logic  rvalid,
    input  logic  rready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rlast
);

    mtime_t mtime;
    logic   rvalid_q;
    data_t  rdata_q;
    resp_t  rresp_q;

    addr_t  offset;
    data_t  rd_word;
    resp_t  rd_resp;
    logic   ar_fire;

    assign offset  = araddr & ~CLINT_MASK;
    assign arready = !rvalid_q;  // one response in flight.
    assign ar_fire = arvalid && arready;

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (offset == MTIME_LO_OFF) begin
            rd_word = mtime[31:0];
        end else if (offset == MTIME_HI_OFF) begin
            rd_word = mtime[63:32];
        end else begin
            rd_resp = RESP_SLVERR;  // unmapped offset.
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // timer word as seen at the address edge.
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;
    assign rresp  = rresp_q;
    assign rlast  = rvalid_q;  // every response is a single beat.

endmodule

// ==== source/cpu_bus_fabric.sv ====
`timescale 1ns/1ps

module cpu_bus_fabric
    import axi_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,

    input  logic   fetch_arvalid,
    output logic   fetch_arready,
    input  addr_t  fetch_araddr,
    input  len_t   fetch_arlen,
    input  size_t  fetch_arsize,
    input  burst_t fetch_arburst,
    output logic   fetch_rvalid,
    input  logic   fetch_rready,
    output data_t  fetch_rdata,
    output resp_t  fetch_rresp,
    output logic   fetch_rlast,

    input  logic   lsu_arvalid,
    output logic   lsu_arready,
    input  addr_t  lsu_araddr,
    input  len_t   lsu_arlen,
    input  size_t  lsu_arsize,
    input  burst_t lsu_arburst,
    output logic   lsu_rvalid,
    input  logic   lsu_rready,
    output data_t  lsu_rdata,
    output resp_t  lsu_rresp,
    output logic   lsu_rlast,
    input  logic   lsu_awvalid,
    output logic   lsu_awready,
    input  addr_t  lsu_awaddr,
    input  len_t   lsu_awlen,
    input  size_t  lsu_awsize,
    input  burst_t lsu_awburst,
    input  logic   lsu_wvalid,
    output logic   lsu_wready,
    input  data_t  lsu_wdata,
    input  strb_t  lsu_wstrb,
    input  logic   lsu_wlast,
    output logic   lsu_bvalid,
    input  logic   lsu_bready,
    output resp_t  lsu_bresp,

    output logic   mem_arvalid,
    input  logic   mem_arready,
    output addr_t  mem_araddr,
    output len_t   mem_arlen,
    output size_t  mem_arsize,
    output burst_t mem_arburst,
    input  logic   mem_rvalid,
    output logic   mem_rready,
    input  data_t  mem_rdata,
    input  resp_t  mem_rresp,
    input  logic   mem_rlast,
    output logic   mem_awvalid,
    input  logic   mem_awready,
    output addr_t  mem_awaddr,
    output len_t   mem_awlen,
    output size_t  mem_awsize,
    output burst_t mem_awburst,
    output logic   mem_wvalid,
    input  logic   mem_wready,
    output data_t  mem_wdata,
    output strb_t  mem_wstrb,
    output logic   mem_wlast,
    input  logic   mem_bvalid,
    output logic   mem_bready,
    input  resp_t  mem_bresp
);

    logic  clint_arvalid;
    logic  clint_arready;
    addr_t clint_araddr;
    logic  clint_rvalid;
    logic  clint_rready;
    data_t clint_rdata;
    resp_t clint_rresp;
    logic  clint_rlast;

    // port names line up one to one.
    read_arbiter read_arbiter_i (.*);

    clint clint_i (
        .clock   (clock        ),
        .rst_n   (rst_n        ),
        .araddr  (clint_araddr ),
        .arvalid (clint_arvalid),
        .arready (clint_arready),
        .rvalid  (clint_rvalid ),
        .rready  (clint_rready ),
        .rdata   (clint_rdata  ),
        .rresp   (clint_rresp  ),
        .rlast   (clint_rlast  )
    );

    // writes only ever target memory.
    assign mem_awvalid = lsu_awvalid;
    assign lsu_awready = mem_awready;
    assign mem_awaddr  = lsu_awaddr;
    assign mem_awlen   = lsu_awlen;
    assign mem_awsize  = lsu_awsize;
    assign mem_awburst = lsu_awburst;

    assign mem_wvalid  = lsu_wvalid;
    assign lsu_wready  = mem_wready;
    assign mem_wdata   = lsu_wdata;
    assign mem_wstrb   = lsu_wstrb;
    assign mem_wlast   = lsu_wlast;

    assign lsu_bvalid  = mem_bvalid;
    assign mem_bready  = lsu_bready;
    assign lsu_bresp   = mem_bresp;

endmodule

// ==== test/cpu_bus_fabric_checker.sv ====
`timescale 1ns/1ps

module cpu_bus_fabric_checker
    import axi_pkg::*;
    import soc_map_pkg::*;
(
    input logic       clock,
    input logic       rst_n,
    input logic       fetch_rvalid,
    input logic       lsu_rvalid,
    input logic       mem_arvalid,
    input logic       mem_arready,
    input addr_t      mem_araddr,
    input arb_state_t arb_state
);

    // only the owner ever sees read data.
    one_rvalid: assert property (@(posedge clock) disable iff (!rst_n)
        !(fetch_rvalid && lsu_rvalid))
        else $error("fetch and load/store read data valid together");

    ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("memory read address dropped or changed before arready");

    idle_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> arb_state == ARB_IDLE)
        else $error("arbiter not idle after reset");

endmodule

bind cpu_bus_fabric cpu_bus_fabric_checker checker_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .fetch_rvalid (fetch_rvalid),
    .lsu_rvalid   (lsu_rvalid),
    .mem_arvalid  (mem_arvalid),
    .mem_arready  (mem_arready),
    .mem_araddr   (mem_araddr),
    .arb_state    (read_arbiter_i.state)
);

// ==== test/cpu_bus_fabric_tb.sv ====
`timescale 1ns/1ps

module cpu_bus_fabric_tb
    import axi_pkg::*;
    import soc_map_pkg::*;
;

    localparam int N_ROWS    = 8;
    localparam int WHO_FETCH = 0;
    localparam int WHO_LSU   = 1;
    localparam int WHO_BOTH  = 2;
    localparam int RULE_PATTERN = 0;
    localparam int RULE_MTIME   = 1;
    localparam int RULE_ZERO    = 2;
    localparam int RULE_WRITE   = 3;

    typedef struct {
        int     who;
        addr_t  addr;    // lsu address, or fetch address for fetch rows.
        len_t   len;
        addr_t  addr2;   // fetch address when both request.
        len_t   len2;
        data_t  wdata;
        strb_t  wstrb;
        resp_t  resp;
        int     rule;
    } row_t;

    logic clock;
    logic rst_n;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready, fetch_rlast;
    addr_t fetch_araddr;
    len_t fetch_arlen;
    size_t fetch_arsize;
    burst_t fetch_arburst;
    data_t fetch_rdata;
    resp_t fetch_rresp;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready, lsu_rlast;
    addr_t lsu_araddr, lsu_awaddr;
    len_t lsu_arlen, lsu_awlen;
    size_t lsu_arsize, lsu_awsize;
    burst_t lsu_arburst, lsu_awburst;
    data_t lsu_rdata, lsu_wdata;
    resp_t lsu_rresp, lsu_bresp;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_wlast;
    logic lsu_bvalid, lsu_bready;
    strb_t lsu_wstrb;
    logic mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    addr_t mem_araddr, mem_awaddr;
    len_t mem_arlen, mem_awlen;
    size_t mem_arsize, mem_awsize;
    burst_t mem_arburst, mem_awburst;
    data_t mem_rdata, mem_wdata;
    resp_t mem_rresp, mem_bresp;
    logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_wlast;
    logic mem_bvalid, mem_bready;
    strb_t mem_wstrb;

    logic [31:0] lfsr = 32'h50a1_671d;
    longint cycle;
    row_t rows[N_ROWS];
    data_t got_data[2][16];
    resp_t got_resp[2][16];
    logic got_last[2][16];
    int got_beats[2];
    size_t got_size[2];
    burst_t got_burst[2];
    longint ar_cycle[2];
    longint first_cycle[2];
    longint end_cycle[2];
    resp_t got_bresp;
    addr_t wr_addr;
    len_t wr_len;
    size_t wr_size;
    burst_t wr_burst;
    data_t wr_data;
    strb_t wr_strb;
    logic wr_last;
    resp_t wr_resp;  // bresp the memory model answers with.

    cpu_bus_fabric cpu_bus_fabric_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic data_t pattern(input addr_t a, input int k);
        return (a + addr_t'(k) * 4) ^ 32'hA5A5_0000;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        assert (act === exp) else
            report_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                     $time, name, exp, act));
    endtask

    // memory model samples on the rising edge and drives on the falling edge.
    initial begin
        logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
        logic rd_busy, got_aw, got_w;
        addr_t rd_addr;
        len_t rd_len;
        len_t rd_beat;
        rd_busy = 0;
        got_aw = 0;
        got_w = 0;
        rd_addr = '0;
        rd_len = '0;
        rd_beat = '0;
        mem_arready = 0;
        mem_rvalid = 0;
        mem_rdata = '0;
        mem_rresp = RESP_OKAY;
        mem_rlast = 0;
        mem_awready = 0;
        mem_wready = 0;
        mem_bvalid = 0;
        mem_bresp = RESP_OKAY;
        forever begin
            @(posedge clock);
            ar_fire = mem_arvalid && mem_arready;
            r_fire = mem_rvalid && mem_rready;
            aw_fire = mem_awvalid && mem_awready;
            w_fire = mem_wvalid && mem_wready;
            b_fire = mem_bvalid && mem_bready;
            if (aw_fire) begin
                wr_addr = mem_awaddr;
                wr_len = mem_awlen;
                wr_size = mem_awsize;
                wr_burst = mem_awburst;
            end
            if (w_fire) begin
                wr_data = mem_wdata;
                wr_strb = mem_wstrb;
                wr_last = mem_wlast;
            end
            @(negedge clock);
            if (r_fire) begin
                if (rd_beat == rd_len) begin
                    rd_busy = 0;
                    mem_rvalid = 0;
                end else begin
                    rd_beat = rd_beat + 8'd1;
                end
            end
            if (ar_fire) begin
                rd_busy = 1;
                rd_addr = mem_araddr;
                rd_len = mem_arlen;
                rd_beat = '0;
            end
            mem_arready = !rd_busy && (rand_bit() || rand_bit());
            if (rd_busy && (!mem_rvalid || r_fire)) begin
                mem_rvalid = rand_bit() || rand_bit();
                mem_rdata = pattern(rd_addr, int'(rd_beat));
                mem_rlast = rd_beat == rd_len;
            end
            got_aw = got_aw || aw_fire;
            got_w = got_w || w_fire;
            if (b_fire) begin
                mem_bvalid = 0;
                got_aw = 0;
                got_w = 0;
            end else if (got_aw && got_w) begin
                mem_bvalid = 1;
                mem_bresp = wr_resp;
            end
            mem_awready = !got_aw && rand_bit();
            mem_wready = !got_w && rand_bit();
        end
    end

    task automatic read_txn(input bit lsu, input addr_t addr, input len_t len);
        bit ar_done;
        bit last_seen;
        logic valid;
        logic rdy;
        int n;
        ar_done = 0;
        last_seen = 0;
        n = 0;
        @(negedge clock);
        if (lsu) begin
            lsu_arvalid = 1;
            lsu_araddr = addr;
            lsu_arlen = len;
        end else begin
            fetch_arvalid = 1;
            fetch_araddr = addr;
            fetch_arlen = len;
        end
        while (!ar_done) begin
            @(posedge clock);
            ar_done = lsu ? (lsu_arvalid && lsu_arready) : (fetch_arvalid && fetch_arready);
        end
        ar_cycle[lsu] = cycle;
        got_size[lsu] = mem_arsize;
        got_burst[lsu] = mem_arburst;
        while (!last_seen) begin
            @(negedge clock);
            if (lsu) begin
                lsu_arvalid = 0;
                lsu_rready = rand_bit() || rand_bit();
            end else begin
                fetch_arvalid = 0;
                fetch_rready = rand_bit() || rand_bit();
            end
            @(posedge clock);
            valid = lsu ? lsu_rvalid : fetch_rvalid;
            rdy = lsu ? lsu_rready : fetch_rready;
            if (valid && rdy) begin
                assert (n < 16) else report_failure("read burst ran past sixteen beats");
                got_data[lsu][n] = lsu ? lsu_rdata : fetch_rdata;
                got_resp[lsu][n] = lsu ? lsu_rresp : fetch_rresp;
                got_last[lsu][n] = lsu ? lsu_rlast : fetch_rlast;
                if (n == 0) first_cycle[lsu] = cycle;
                end_cycle[lsu] = cycle;
                last_seen = got_last[lsu][n];
                n++;
            end
        end
        got_beats[lsu] = n;
        @(negedge clock);
        lsu_rready = lsu ? 1'b0 : lsu_rready;
        fetch_rready = lsu ? fetch_rready : 1'b0;
    endtask

    task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb);
        bit aw_done;
        bit w_done;
        bit b_done;
        aw_done = 0;
        w_done = 0;
        b_done = 0;
        @(negedge clock);
        lsu_awvalid = 1;
        lsu_awaddr = addr;
        lsu_wvalid = 1;
        lsu_wdata = data;
        lsu_wstrb = strb;
        while (!b_done) begin
            @(posedge clock);
            if (lsu_awvalid && lsu_awready) aw_done = 1;
            if (lsu_wvalid && lsu_wready) w_done = 1;
            if (lsu_bvalid && lsu_bready) begin
                b_done = 1;
                got_bresp = lsu_bresp;
            end
            @(negedge clock);
            if (aw_done) lsu_awvalid = 0;
            if (w_done) lsu_wvalid = 0;
            lsu_bready = !b_done && rand_bit();
        end
    endtask

    task automatic check_beats(input bit lsu, input addr_t addr, input len_t len,
                               input resp_t resp);
        string who;
        who = lsu ? "lsu" : "fetch";
        check_value({who, " beat count"}, data_t'(len) + 1, data_t'(got_beats[lsu]));
        check_value("mem_arsize", data_t'(lsu ? lsu_arsize : fetch_arsize),
                    data_t'(got_size[lsu]));
        check_value("mem_arburst", data_t'(lsu ? lsu_arburst : fetch_arburst),
                    data_t'(got_burst[lsu]));
        for (int k = 0; k <= int'(len); k++) begin
            check_value({who, "_rdata"}, pattern(addr, k), got_data[lsu][k]);
            check_value({who, "_rresp"}, data_t'(resp), data_t'(got_resp[lsu][k]));
            check_value({who, "_rlast"}, data_t'(k == int'(len)), data_t'(got_last[lsu][k]));
        end
    endtask

    initial begin
        rows[0] = '{WHO_FETCH, 32'h0000_1000, 8'd3, '0, '0, '0, '0, RESP_OKAY, RULE_PATTERN};
        rows[1] = '{WHO_LSU, 32'h0000_2004, 8'd0, '0, '0, '0, '0, RESP_OKAY, RULE_PATTERN};
        rows[2] = '{WHO_LSU, CLINT_BASE + MTIME_LO_OFF, 8'd0, '0, '0, '0, '0, RESP_OKAY,
                    RULE_MTIME};
        rows[3] = '{WHO_LSU, CLINT_BASE + MTIME_LO_OFF, 8'd0, '0, '0, '0, '0, RESP_OKAY,
                    RULE_MTIME};
        rows[4] = '{WHO_LSU, CLINT_BASE + MTIME_HI_OFF, 8'd0, '0, '0, '0, '0, RESP_OKAY,
                    RULE_ZERO};
        rows[5] = '{WHO_LSU, CLINT_BASE + 32'h8, 8'd0, '0, '0, '0, '0, RESP_SLVERR, RULE_ZERO};
        rows[6] = '{WHO_BOTH, 32'h0000_3000, 8'd0, 32'h0000_4000, 8'd3, '0, '0, RESP_OKAY,
                    RULE_PATTERN};
        rows[7] = '{WHO_LSU, 32'h0000_5008, 8'd0, '0, '0, 32'hDEAD_BEEF, 4'h6, RESP_EXOKAY,
                    RULE_WRITE};
    end

    initial begin
        repeat (N_ROWS * 200) @(posedge clock);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        longint prev_mtime;
        row_t row;
        prev_mtime = -1;
        rst_n = 0;
        wr_resp = RESP_OKAY;
        fetch_arvalid = 0;
        fetch_araddr = '0;
        fetch_arlen = '0;
        fetch_arsize = SIZE_WORD;
        fetch_arburst = BURST_INCR;
        fetch_rready = 0;
        lsu_arvalid = 0;
        lsu_araddr = '0;
        lsu_arlen = '0;
        lsu_arsize = SIZE_WORD;
        lsu_arburst = BURST_FIXED;
        lsu_rready = 0;
        lsu_awvalid = 0;
        lsu_awaddr = '0;
        lsu_awlen = '0;
        lsu_awsize = SIZE_WORD;
        lsu_awburst = BURST_INCR;
        lsu_wvalid = 0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        lsu_wlast = 1;
        lsu_bready = 0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1;
        for (int r = 0; r < N_ROWS; r++) begin
            row = rows[r];
            if (row.rule == RULE_WRITE) begin
                wr_resp = row.resp;
                write_txn(row.addr, row.wdata, row.wstrb);
                check_value("mem_awaddr", row.addr, wr_addr);
                check_value("mem_awlen", data_t'(lsu_awlen), data_t'(wr_len));
                check_value("mem_awsize", data_t'(lsu_awsize), data_t'(wr_size));
                check_value("mem_awburst", data_t'(lsu_awburst), data_t'(wr_burst));
                check_value("mem_wdata", row.wdata, wr_data);
                check_value("mem_wstrb", data_t'(row.wstrb), data_t'(wr_strb));
                check_value("mem_wlast", data_t'(lsu_wlast), data_t'(wr_last));
                check_value("lsu_bresp", data_t'(row.resp), data_t'(got_bresp));
            end else if (row.who == WHO_BOTH) begin
                fork
                    read_txn(1'b1, row.addr, row.len);
                    read_txn(1'b0, row.addr2, row.len2);
                join
                check_beats(1'b1, row.addr, row.len, row.resp);
                check_beats(1'b0, row.addr2, row.len2, row.resp);
                assert (end_cycle[1] < first_cycle[0]) else
                    report_failure("fetch data arrived before the load/store read finished");
            end else if (row.rule == RULE_PATTERN) begin
                read_txn(row.who == WHO_LSU, row.addr, row.len);
                check_beats(row.who == WHO_LSU, row.addr, row.len, row.resp);
            end else begin
                read_txn(1'b1, row.addr, row.len);
                check_value("lsu beat count", 32'd1, data_t'(got_beats[1]));
                check_value("lsu_rresp", data_t'(row.resp), data_t'(got_resp[1][0]));
                check_value("lsu_rlast", 32'd1, data_t'(got_last[1][0]));
                if (row.rule == RULE_ZERO) begin
                    check_value("lsu_rdata", 32'd0, got_data[1][0]);
                end else begin
                    assert (longint'(got_data[1][0]) >= ar_cycle[1] &&
                            longint'(got_data[1][0]) <= end_cycle[1] &&
                            longint'(got_data[1][0]) > prev_mtime) else
                        report_failure($sformatf(
                            "** Error at %0t: lsu_rdata expected %0d..%0d above %0d, got %0d",
                            $time, ar_cycle[1], end_cycle[1], prev_mtime, got_data[1][0]));
                    prev_mtime = longint'(got_data[1][0]);
                end
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== compile.f ====
common/axi_pkg.sv
common/soc_map_pkg.sv
bus/read_arbiter.sv
clint/clint.sv
source/cpu_bus_fabric.sv
test/cpu_bus_fabric_checker.sv
test/cpu_bus_fabric_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module cpu_bus_fabric_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vcpu_bus_fabric_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
